/* hw/hw_mgr_config.svh */
`ifndef HW_MGR_CONFIG_SVH
`define HW_MGR_CONFIG_SVH

// Boards in the chassis, one mask bit each
`define HW_MGR_NUM_BOARDS 8

// Sequencer delays in clk cycles, cut down for simulation
// A delay state with value N lasts N+1 cycles
`define HW_MGR_SD_FORCE_DELAY 20   // Force released -> reset pulse
`define HW_MGR_SD_RST_PULSE 5      // Low time of n_shutdown_rst
`define HW_MGR_SD_RST_DELAY 20     // Reset pulse done -> DMA start

// Boot timeouts, also in clk cycles
`define HW_MGR_BUF_LOAD_WAIT 50    // DAC buffer preload after dma_en
`define HW_MGR_SPI_START_WAIT 50   // SPI up after spi_en

// Wide enough for the full-length hardware delays too
`define HW_MGR_TIMER_W 32

`endif

/* hw/hw_mgr_fault_pkg.sv */
`include "hw_mgr_config.svh"

package hw_mgr_fault_pkg;

  typedef logic [`HW_MGR_NUM_BOARDS-1:0] board_mask_t;          // Bit i is board i
  typedef logic [$clog2(`HW_MGR_NUM_BOARDS)-1:0] board_idx_t;

  // Config out-of-bounds flags, first field wins
  typedef struct packed {
    logic trig_lockout;
    logic cal_offset;
    logic dac_divider;
    logic integ_thresh_avg;
    logic integ_window;
    logic integ_en;
    logic sys_en;
  } cfg_oob_t;

  // Run-time faults
  // Priority is lock_viol, shutdown_sense, ext_shutdown, then masks in order
  typedef struct packed {
    logic        lock_viol;
    logic        ext_shutdown;
    board_mask_t shutdown_sense;
    board_mask_t dac_over_thresh;
    board_mask_t adc_over_thresh;
    board_mask_t dac_buf_underflow;
    board_mask_t dac_buf_overflow;
    board_mask_t adc_buf_underflow;
    board_mask_t adc_buf_overflow;
  } run_fault_t;

  // Control lines out to the rest of the system
  typedef struct packed {
    logic sys_rst;
    logic unlock_cfg;        // High lets the PS write config
    logic dma_en;
    logic spi_en;
    logic trig_en;
    logic n_shutdown_force;  // Active low
    logic n_shutdown_rst;    // Active low
  } hw_ctrl_t;

endpackage

/* hw/hw_mgr_status_pkg.sv */
package hw_mgr_status_pkg;

  // Sequencer state, zero is not a legal encoding
  typedef enum logic [3:0] {
    IDLE         = 4'd1,
    RELEASE_SD_F = 4'd2,  // Shutdown force released, waiting
    PULSE_SD_RST = 4'd3,  // n_shutdown_rst held low
    SD_RST_DELAY = 4'd4,
    START_DMA    = 4'd5,  // Waiting on DAC buffer preload
    START_SPI    = 4'd6,  // Waiting on SPI
    RUNNING      = 4'd7,
    HALTED       = 4'd8
  } hw_state_t;

  // Status codes, numbering kept from the full board manager
  // Gaps at 15-18 and 23-26 belong to faults not monitored here
  typedef enum logic [24:0] {
    OK                   = 25'd1,
    PS_SHUTDOWN          = 25'd2,
    TRIG_LOCKOUT_OOB     = 25'd3,
    CAL_OFFSET_OOB       = 25'd4,
    DAC_DIVIDER_OOB      = 25'd5,
    INTEG_THRESH_AVG_OOB = 25'd6,
    INTEG_WINDOW_OOB     = 25'd7,
    INTEG_EN_OOB         = 25'd8,
    SYS_EN_OOB           = 25'd9,
    LOCK_VIOL            = 25'd10,
    SHUTDOWN_SENSE       = 25'd11,
    EXT_SHUTDOWN         = 25'd12,
    DAC_OVER_THRESH      = 25'd13,
    ADC_OVER_THRESH      = 25'd14,
    DAC_BUF_UNDERFLOW    = 25'd19,
    DAC_BUF_OVERFLOW     = 25'd20,
    ADC_BUF_UNDERFLOW    = 25'd21,
    ADC_BUF_OVERFLOW     = 25'd22,
    BUF_FILL_TIMEOUT     = 25'd27,
    SPI_START_TIMEOUT    = 25'd28
  } status_code_t;

  // Word read by the PS, board on top, state in the low nibble
  typedef struct packed {
    hw_mgr_fault_pkg::board_idx_t board;
    status_code_t                 code;
    hw_state_t                    state;
  } status_word_t;

endpackage

/* hw/cfg_bounds_check.sv */
`timescale 1ns/1ps

module cfg_bounds_check (
  input  hw_mgr_fault_pkg::cfg_oob_t      cfg_oob,
  output logic                            cfg_hit,
  output hw_mgr_status_pkg::status_code_t cfg_code
);
  import hw_mgr_status_pkg::*;
  import hw_mgr_fault_pkg::*;

  // First flag in struct order sets the code
  always_comb begin
    cfg_hit = 1'b1;
    if (cfg_oob.trig_lockout) begin
      cfg_code = TRIG_LOCKOUT_OOB;
    end else if (cfg_oob.cal_offset) begin
      cfg_code = CAL_OFFSET_OOB;
    end else if (cfg_oob.dac_divider) begin
      cfg_code = DAC_DIVIDER_OOB;
    end else if (cfg_oob.integ_thresh_avg) begin
      cfg_code = INTEG_THRESH_AVG_OOB;
    end else if (cfg_oob.integ_window) begin
      cfg_code = INTEG_WINDOW_OOB;
    end else if (cfg_oob.integ_en) begin
      cfg_code = INTEG_EN_OOB;
    end else if (cfg_oob.sys_en) begin
      cfg_code = SYS_EN_OOB;
    end else begin
      cfg_hit  = 1'b0;  // Config clean so boot may go ahead
      cfg_code = OK;
    end

    // Chain must cover every flag of the struct
    // Flags not yet driven at start-up are skipped
    a_hit_any_flag: assert ($isunknown(cfg_oob) || cfg_hit == (|cfg_oob))
      else $error("cfg_hit %0b disagrees with flags %h", cfg_hit, cfg_oob);
  end

endmodule

/* hw/fault_priority_encoder.sv */
`timescale 1ns/1ps

module fault_priority_encoder (
  input  logic                            sys_en,
  input  hw_mgr_fault_pkg::run_fault_t    faults,
  output logic                            fault_hit,
  output hw_mgr_status_pkg::status_code_t fault_code,
  output hw_mgr_fault_pkg::board_idx_t    fault_board
);
  import hw_mgr_status_pkg::*;
  import hw_mgr_fault_pkg::*;

  board_mask_t mask_sel;  // Mask of the winning fault, zero if not per board

  // Lowest set bit, scanned from the top so the last hit wins
  function automatic board_idx_t lowest_board(input board_mask_t mask);
    board_idx_t idx;
    idx = '0;
    for (int i = $bits(board_mask_t) - 1; i >= 0; i--) begin
      if (mask[i]) idx = board_idx_t'(i);
    end
    return idx;
  endfunction

  always_comb begin
    fault_hit = 1'b1;
    mask_sel  = '0;
    if (!sys_en) begin
      fault_code = PS_SHUTDOWN;  // PS pulled the enable
    end else if (faults.lock_viol) begin
      fault_code = LOCK_VIOL;
    end else if (|faults.shutdown_sense) begin
      fault_code = SHUTDOWN_SENSE;
      mask_sel   = faults.shutdown_sense;
    end else if (faults.ext_shutdown) begin
      fault_code = EXT_SHUTDOWN;
    end else if (|faults.dac_over_thresh) begin
      fault_code = DAC_OVER_THRESH;
      mask_sel   = faults.dac_over_thresh;
    end else if (|faults.adc_over_thresh) begin
      fault_code = ADC_OVER_THRESH;
      mask_sel   = faults.adc_over_thresh;
    end else if (|faults.dac_buf_underflow) begin
      fault_code = DAC_BUF_UNDERFLOW;
      mask_sel   = faults.dac_buf_underflow;
    end else if (|faults.dac_buf_overflow) begin
      fault_code = DAC_BUF_OVERFLOW;
      mask_sel   = faults.dac_buf_overflow;
    end else if (|faults.adc_buf_underflow) begin
      fault_code = ADC_BUF_UNDERFLOW;
      mask_sel   = faults.adc_buf_underflow;
    end else if (|faults.adc_buf_overflow) begin
      fault_code = ADC_BUF_OVERFLOW;
      mask_sel   = faults.adc_buf_overflow;
    end else begin
      fault_hit  = 1'b0;
      fault_code = OK;
    end
    fault_board = lowest_board(mask_sel);  // 0 for the global faults

    // A halt must never be logged as OK
    a_hit_has_code: assert (!fault_hit || fault_code != OK)
      else $error("fault_hit with code OK, faults %h", faults);
  end

endmodule

/* hw/power_sequencer.sv */
`timescale 1ns/1ps
`include "hw_mgr_config.svh"

module power_sequencer (
  input  logic                            clk,
  input  logic                            rst,
  input  logic                            sys_en,
  input  logic                            dac_buf_loaded,
  input  logic                            spi_running,
  input  logic                            cfg_hit,
  input  hw_mgr_status_pkg::status_code_t cfg_code,
  input  logic                            fault_hit,
  input  hw_mgr_status_pkg::status_code_t fault_code,
  input  hw_mgr_fault_pkg::board_idx_t    fault_board,
  output hw_mgr_fault_pkg::hw_ctrl_t      ctrl,
  output hw_mgr_status_pkg::status_word_t status_word,
  output logic                            ps_interrupt
);
  import hw_mgr_status_pkg::*;
  import hw_mgr_fault_pkg::*;

  hw_state_t                  cur_state;
  status_code_t               status_code;
  board_idx_t                 board_num;
  logic [`HW_MGR_TIMER_W-1:0] timer;  // Free running, cleared on state change

  assign status_word = '{board: board_num, code: status_code, state: cur_state};

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      cur_state    <= IDLE;
      timer        <= '0;
      status_code  <= OK;
      board_num    <= '0;
      ps_interrupt <= 1'b0;
      ctrl <= '{sys_rst: 1'b1, unlock_cfg: 1'b1, dma_en: 1'b0, spi_en: 1'b0,
                trig_en: 1'b0, n_shutdown_force: 1'b0, n_shutdown_rst: 1'b1};
    end else begin
      ps_interrupt <= 1'b0;  // One-cycle pulse unless set below
      timer        <= timer + 1'b1;
      case (cur_state)
        IDLE: begin
          if (sys_en && cfg_hit) begin
            // Bad config, hardware stays off and config stays open
            cur_state    <= HALTED;
            status_code  <= cfg_code;
            ps_interrupt <= 1'b1;
          end else if (sys_en) begin
            cur_state             <= RELEASE_SD_F;
            timer                 <= '0;
            ctrl.sys_rst          <= 1'b0;
            ctrl.unlock_cfg       <= 1'b0;  // Config locked from here on
            ctrl.n_shutdown_force <= 1'b1;
          end
        end
        RELEASE_SD_F: if (timer >= `HW_MGR_SD_FORCE_DELAY) begin
          cur_state           <= PULSE_SD_RST;
          timer               <= '0;
          ctrl.n_shutdown_rst <= 1'b0;
        end
        PULSE_SD_RST: if (timer >= `HW_MGR_SD_RST_PULSE) begin
          cur_state           <= SD_RST_DELAY;
          timer               <= '0;
          ctrl.n_shutdown_rst <= 1'b1;  // End of the pulse
        end
        SD_RST_DELAY: if (timer >= `HW_MGR_SD_RST_DELAY) begin
          cur_state   <= START_DMA;
          timer       <= '0;
          ctrl.dma_en <= 1'b1;
        end
        START_DMA: begin
          if (dac_buf_loaded) begin
            cur_state   <= START_SPI;
            timer       <= '0;
            ctrl.spi_en <= 1'b1;
          end else if (timer >= `HW_MGR_BUF_LOAD_WAIT) begin
            // Buffer never filled, power back down
            cur_state             <= HALTED;
            status_code           <= BUF_FILL_TIMEOUT;
            ps_interrupt          <= 1'b1;
            ctrl.sys_rst          <= 1'b1;
            ctrl.n_shutdown_force <= 1'b0;
            ctrl.dma_en           <= 1'b0;
            ctrl.spi_en           <= 1'b0;
          end
        end
        START_SPI: begin
          if (spi_running) begin
            cur_state    <= RUNNING;
            ctrl.trig_en <= 1'b1;
            ps_interrupt <= 1'b1;  // Tell the PS the system is live
          end else if (timer >= `HW_MGR_SPI_START_WAIT) begin
            cur_state             <= HALTED;
            status_code           <= SPI_START_TIMEOUT;
            ps_interrupt          <= 1'b1;
            ctrl.sys_rst          <= 1'b1;
            ctrl.n_shutdown_force <= 1'b0;
            ctrl.dma_en           <= 1'b0;
            ctrl.spi_en           <= 1'b0;
          end
        end
        RUNNING: begin
          // Fault acted on once the entry pulse is done, keeps pulses apart
          if (fault_hit && !ps_interrupt) begin
            cur_state             <= HALTED;
            status_code           <= fault_code;
            board_num             <= fault_board;
            ps_interrupt          <= 1'b1;
            ctrl.sys_rst          <= 1'b1;
            ctrl.n_shutdown_force <= 1'b0;
            ctrl.dma_en           <= 1'b0;
            ctrl.spi_en           <= 1'b0;
            ctrl.trig_en          <= 1'b0;
          end
        end
        HALTED: if (!sys_en) begin
          // PS acknowledged by dropping the enable
          cur_state       <= IDLE;
          status_code     <= OK;
          board_num       <= '0;
          ctrl.unlock_cfg <= 1'b1;
        end
        default: cur_state <= IDLE;
      endcase
    end
  end

  a_irq_single: assert property (@(posedge clk) disable iff (rst)
    ps_interrupt |=> !ps_interrupt);
  a_trig_only_running: assert property (@(posedge clk) disable iff (rst)
    ctrl.trig_en |-> cur_state == RUNNING);
  a_state_legal: assert property (@(posedge clk) disable iff (rst)
    cur_state inside {[IDLE:HALTED]});

endmodule

/* hw/hw_manager.sv */
`timescale 1ns/1ps

module hw_manager (
  input  logic                            clk,
  input  logic                            rst,
  input  logic                            sys_en,
  input  logic                            dac_buf_loaded,
  input  logic                            spi_running,
  input  hw_mgr_fault_pkg::cfg_oob_t      cfg_oob,
  input  hw_mgr_fault_pkg::run_fault_t    faults,
  output hw_mgr_fault_pkg::hw_ctrl_t      ctrl,
  output hw_mgr_status_pkg::status_word_t status_word,
  output logic                            ps_interrupt
);
  import hw_mgr_status_pkg::*;
  import hw_mgr_fault_pkg::*;

  logic         cfg_hit;
  status_code_t cfg_code;
  logic         fault_hit;
  status_code_t fault_code;
  board_idx_t   fault_board;

  // Checked on boot only
  cfg_bounds_check u_cfg_check (.cfg_oob, .cfg_hit, .cfg_code);

  // Watched in RUNNING, sys_en low counts as a fault
  fault_priority_encoder u_fault_enc (
    .sys_en, .faults, .fault_hit, .fault_code, .fault_board
  );

  power_sequencer u_seq (
    .clk, .rst, .sys_en, .dac_buf_loaded, .spi_running,
    .cfg_hit, .cfg_code, .fault_hit, .fault_code, .fault_board,
    .ctrl, .status_word, .ps_interrupt
  );

endmodule

/* testbench/tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen (
  output logic clk,
  output logic rst
);
  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;  // 4 ns period
  end

  initial begin
    rst = 1'b1;
    repeat (10) @(posedge clk);  // Reset held for 10 cycles
    #1 rst = 1'b0;
  end
endmodule

/* testbench/hw_manager_tb.sv */
`timescale 1ns/1ps
`include "hw_mgr_config.svh"

module hw_manager_tb;
  import hw_mgr_status_pkg::*;
  import hw_mgr_fault_pkg::*;

  // Bit order sys_rst unlock dma spi trig n_force n_rst
  localparam hw_ctrl_t CTRL_RESET     = 7'b1100001;
  localparam hw_ctrl_t CTRL_BOOT_HALT = 7'b1000001;  // Config stays locked
  localparam hw_ctrl_t CTRL_RUN       = 7'b0011111;
  // IDLE edge plus the three delay states, each N+1 cycles
  localparam int BOOT_CYCLES = 1 + (`HW_MGR_SD_FORCE_DELAY + 1) +
                               (`HW_MGR_SD_RST_PULSE + 1) + (`HW_MGR_SD_RST_DELAY + 1);

  typedef struct packed {
    cfg_oob_t     cfg;
    int           buf_dly;  // 0 never loads
    int           spi_dly;  // 0 never runs
    logic         drop_en;  // Also drop sys_en in RUNNING
    run_fault_t   fault;
    status_word_t exp_status;
    hw_ctrl_t     exp_ctrl;
  } row_t;

  logic         clk, rst, sys_en, dac_buf_loaded, spi_running;
  cfg_oob_t     cfg_oob;
  run_fault_t   faults;
  hw_ctrl_t     ctrl;
  status_word_t status_word;
  logic         ps_interrupt;
  row_t         rows[$];
  int           errors = 0;
  int           timeouts = 0;
  int           seed = 5231;
  int           cycles;
  logic         ok;

  tb_clock_gen u_clk (.clk, .rst);

  hw_manager DUT (.clk, .rst, .sys_en, .dac_buf_loaded, .spi_running, .cfg_oob, .faults,
                  .ctrl, .status_word, .ps_interrupt);

  task automatic next_cycle;
    @(posedge clk);
    #1;  // Drive and sample just past the edge
  endtask

  task automatic check_status(input string what, input status_word_t exp);
    if (status_word !== exp) begin
      errors++;
      $display("** Error %s status_word: got %h, expected %h", what, status_word, exp);
    end
  endtask

  task automatic check_ctrl(input string what, input hw_ctrl_t exp);
    if (ctrl !== exp) begin
      errors++;
      $display("** Error %s ctrl: got %h, expected %h", what, ctrl, exp);
    end
  endtask

  // High now, low on the next cycle
  task automatic check_irq(input string what);
    if (ps_interrupt !== 1'b1) begin
      errors++;
      $display("** Error %s ps_interrupt: got %h, expected %h", what, ps_interrupt, 1'b1);
    end
    next_cycle();
    if (ps_interrupt !== 1'b0) begin
      errors++;
      $display("** Error %s ps_interrupt: got %h, expected %h", what, ps_interrupt, 1'b0);
    end
  endtask

  // Returns the number of edges it took, 0 if already there
  task automatic wait_state(input hw_state_t st, output int n, output logic found);
    found = 1'b0;
    for (n = 0; n <= 300 && !found; n++) begin
      if (status_word.state == st) found = 1'b1;
      else next_cycle();
    end
    n = n - 1;
    if (!found) begin
      timeouts++;
      $display("Timeout waiting for state %0d", st);
    end
  endtask

  // Sit in a boot wait state, raising its level input after dly cycles
  task automatic wait_leave(input hw_state_t st, input int dly, input logic spi,
                            output logic found);
    found = 1'b0;
    for (int i = 0; i < 300 && !found; i++) begin
      if (dly != 0 && i == dly) begin
        if (spi) spi_running = 1'b1;
        else dac_buf_loaded = 1'b1;
      end
      next_cycle();
      found = (status_word.state != st);
    end
    if (!found) begin
      timeouts++;
      $display("Timeout, sequencer stuck in state %0d", st);
    end
  endtask

  function automatic board_idx_t lowest_set(input board_mask_t m);
    for (int i = 0; i < `HW_MGR_NUM_BOARDS; i++) begin
      if (m[i]) return i;
    end
    return 0;
  endfunction

  task automatic add_row(input cfg_oob_t cfg, input int buf_dly, input int spi_dly,
                         input logic drop, input run_fault_t fault,
                         input status_code_t code, input board_idx_t board);
    row_t row;
    row.cfg        = cfg;
    row.buf_dly    = buf_dly;
    row.spi_dly    = spi_dly;
    row.drop_en    = drop;
    row.fault      = fault;
    row.exp_status = {board, code, HALTED};
    row.exp_ctrl   = (cfg != '0) ? CTRL_RESET : CTRL_BOOT_HALT;  // Bounds halt leaves ctrl alone
    rows.push_back(row);
  endtask

  task automatic build_table;
    board_mask_t m1, m2;
    // Fault word {lock_viol, ext_sd, 56'h sense_dot_aot_dbu_dbo_abu_abo}
    add_row(7'h25, 0, 0, 1'b0, '0, CAL_OFFSET_OOB, 3'd0);
    add_row(7'h03, 0, 0, 1'b0, '0, INTEG_EN_OOB, 3'd0);
    add_row(7'h50, 0, 0, 1'b0, '0, TRIG_LOCKOUT_OOB, 3'd0);
    add_row(7'h00, 0, 5, 1'b0, '0, BUF_FILL_TIMEOUT, 3'd0);
    add_row(7'h00, 4, 0, 1'b0, '0, SPI_START_TIMEOUT, 3'd0);
    add_row(7'h00, 1, 1, 1'b0, {2'b11, 56'h30_04_00_00_00_00_00}, LOCK_VIOL, 3'd0);
    add_row(7'h00, 3, 2, 1'b0, {2'b01, 56'h60_00_00_00_00_00_01}, SHUTDOWN_SENSE, 3'd5);
    add_row(7'h00, 2, 6, 1'b0, {2'b01, 56'h00_04_00_00_00_00_00}, EXT_SHUTDOWN, 3'd0);
    add_row(7'h00, 7, 1, 1'b0, {2'b00, 56'h00_90_00_00_00_02_00}, DAC_OVER_THRESH, 3'd4);
    add_row(7'h00, 1, 9, 1'b0, {2'b00, 56'h00_00_00_02_48_00_00}, DAC_BUF_UNDERFLOW, 3'd1);
    add_row(7'h00, 5, 3, 1'b0, {2'b00, 56'h00_00_00_00_48_00_0f}, DAC_BUF_OVERFLOW, 3'd3);
    add_row(7'h00, 2, 2, 1'b0, {2'b00, 56'h00_00_00_00_00_80_01}, ADC_BUF_UNDERFLOW, 3'd7);
    add_row(7'h00, 6, 4, 1'b0, {2'b00, 56'h00_00_00_00_00_00_06}, ADC_BUF_OVERFLOW, 3'd1);
    add_row(7'h00, 2, 2, 1'b1, {2'b11, 56'h01_00_00_00_00_00_00}, PS_SHUTDOWN, 3'd0);
    for (int i = 0; i < 3; i++) begin
      m1 = $random(seed);
      m2 = $random(seed);
      if (m1 == '0) m1 = 8'h80;  // Need at least one failing board
      add_row(7'h00, 1 + i, 2 + i, 1'b0, {2'b00, 16'h0, m1, m2, 16'h0, m2},
              ADC_OVER_THRESH, lowest_set(m1));
    end
  endtask

  initial begin
    sys_en         = 1'b0;
    dac_buf_loaded = 1'b0;
    spi_running    = 1'b0;
    cfg_oob        = '0;
    faults         = '0;
    build_table();
    repeat (11) next_cycle();  // Reset length fixed by the clock module
    check_status("reset", {3'd0, OK, IDLE});
    check_ctrl("reset", CTRL_RESET);
    if (ps_interrupt !== 1'b0) begin
      errors++;
      $display("** Error reset ps_interrupt: got %h, expected %h", ps_interrupt, 1'b0);
    end

    for (int r = 0; r < rows.size(); r++) begin
      sys_en         = 1'b0;  // Release any halt from the last row
      dac_buf_loaded = 1'b0;
      spi_running    = 1'b0;
      faults         = '0;
      wait_state(IDLE, cycles, ok);
      check_status("release", {3'd0, OK, IDLE});
      check_ctrl("release", CTRL_RESET);
      cfg_oob = rows[r].cfg;
      sys_en  = 1'b1;
      if (rows[r].cfg == '0) begin
        wait_state(START_DMA, cycles, ok);
        if (ok && cycles != BOOT_CYCLES) begin
          errors++;
          $display("** Error row %0d boot cycles: got %h, expected %h", r, cycles, BOOT_CYCLES);
        end
        wait_leave(START_DMA, rows[r].buf_dly, 1'b0, ok);
        if (status_word.state == START_SPI) wait_leave(START_SPI, rows[r].spi_dly, 1'b1, ok);
        if (status_word.state == RUNNING) begin
          check_ctrl("running", CTRL_RUN);
          check_irq("running");
          faults = rows[r].fault;
          if (rows[r].drop_en) sys_en = 1'b0;  // PS shutdown beats any fault
        end
      end
      wait_state(HALTED, cycles, ok);
      check_status("halted", rows[r].exp_status);
      check_ctrl("halted", rows[r].exp_ctrl);
      check_irq("halted");
    end

    $display("Done: %0d errors, %0d timeouts", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end
endmodule

/* sources.f */
+incdir+hw
hw/hw_mgr_fault_pkg.sv
hw/hw_mgr_status_pkg.sv
hw/cfg_bounds_check.sv
hw/fault_priority_encoder.sv
hw/power_sequencer.sv
hw/hw_manager.sv
testbench/tb_clock_gen.sv
testbench/hw_manager_tb.sv

/* Bender.yml */
package:
  name: hw_manager

sources:
  - include_dirs:
      - hw
    files:
      - hw/hw_mgr_fault_pkg.sv
      - hw/hw_mgr_status_pkg.sv
      - hw/cfg_bounds_check.sv
      - hw/fault_priority_encoder.sv
      - hw/power_sequencer.sv
      - hw/hw_manager.sv
  - target: test
    include_dirs:
      - hw
    files:
      - testbench/tb_clock_gen.sv
      - testbench/hw_manager_tb.sv
